// File: hw/adc_spi_macros.svh
`ifndef ADC_SPI_MACROS_SVH
`define ADC_SPI_MACROS_SVH

// ----------------------------------------------------------------------
// Frame geometry
// ----------------------------------------------------------------------

`define ADC_WORD_BITS 32 // Bits per SPI word, MSB first
`define ADC_READ_WORDS 5 // Status word plus one word per channel
`define ADC_CHANNELS 4

// Init sequence length, one command per frame
`define ADC_INIT_STEPS 9

// ----------------------------------------------------------------------
// ADC reset timing in system clock cycles
// ----------------------------------------------------------------------

`define ADC_RESET_LOW_CYCLES 41665 // About 5 ms reset pulse
`define ADC_RESET_WAIT_CYCLES 166660 // About 20 ms recovery

`endif

// File: hw/adc_spi_pkg.sv
`default_nettype none

`include "adc_spi_macros.svh"

package adc_spi_pkg;

	// Vector types with a meaning
	typedef logic [`ADC_WORD_BITS-1:0] spi_word_t;
	typedef logic [3:0] init_step_t; // Index into the init command table
	typedef logic [2:0] frame_len_t; // Word count or word index within a frame
	typedef logic [17:0] reset_count_t;

	// Controller FSM
	typedef enum logic [2:0] {
		ST_RESET_LOW,
		ST_RESET_WAIT,
		ST_INIT_SEND,
		ST_INIT_WAIT,
		ST_READY,
		ST_READ_WAIT
	} ctrl_state_e;

	// Frame request from the controller to the frame engine
	typedef struct packed {
		logic start; // One-cycle strobe
		spi_word_t tx_word; // Sent in the first word only
		frame_len_t word_count;
		logic read; // Read frame, words go into the sample
	} frame_req_t;

	// One received word
	typedef struct packed {
		logic valid;
		frame_len_t index;
		spi_word_t data;
	} rx_word_t;

	// Full conversion result of one read frame
	typedef struct packed {
		spi_word_t status;
		spi_word_t [`ADC_CHANNELS-1:0] channel;
	} adc_sample_t;

	// Decoded init step
	typedef struct packed {
		spi_word_t cmd;
		spi_word_t expected; // Reply expected in the first word
		logic last;
	} init_cmd_t;

endpackage

`default_nettype wire

// File: hw/adc_init_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "adc_spi_macros.svh"

module adc_init_decoder
	import adc_spi_pkg::*;
(
	input wire init_step_t step_i,
	output init_cmd_t cmd_o
);

	localparam init_step_t LAST_STEP = init_step_t'(`ADC_INIT_STEPS - 1);

	// ----------------------------------------------------------------------
	// Command table, reply words sit in the upper half
	// ----------------------------------------------------------------------
	always_comb begin
		cmd_o.last = (step_i == LAST_STEP);
		case (step_i)
			4'd1: {cmd_o.cmd, cmd_o.expected} = {32'h0655_0000, 32'h0655_0000}; // Unlock
			4'd2: {cmd_o.cmd, cmd_o.expected} = {32'h4B68_0000, 32'h2B68_0000};
			4'd3: {cmd_o.cmd, cmd_o.expected} = {32'h4C3E_0000, 32'h2C3E_0000};
			4'd4: {cmd_o.cmd, cmd_o.expected} = {32'h4D02_0000, 32'h2D02_0000};
			4'd5: {cmd_o.cmd, cmd_o.expected} = {32'h4E25_0000, 32'h2E25_0000};
			4'd6: {cmd_o.cmd, cmd_o.expected} = {32'h4F0F_0000, 32'h2F0F_0000};
			4'd7: {cmd_o.cmd, cmd_o.expected} = {32'h0033_0000, 32'h0033_0000}; // Wakeup
			4'd8: {cmd_o.cmd, cmd_o.expected} = {32'h0555_0000, 32'h0555_0000}; // Lock
			// Step 0 and anything out of range read the reset status
			default: {cmd_o.cmd, cmd_o.expected} = {32'h0000_0000, 32'hFF04_0000};
		endcase
	end

	// The controller never steps past the last entry
	always_comb begin
		assert ($isunknown(step_i) || step_i <= LAST_STEP)
			else $error("init step %0d out of range", step_i);
	end

endmodule

`default_nettype wire

// File: hw/adc_sequence_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "adc_spi_macros.svh"

module adc_sequence_ctrl
	import adc_spi_pkg::*;
#(
	parameter int RESET_LOW_CYCLES = `ADC_RESET_LOW_CYCLES,
	parameter int RESET_WAIT_CYCLES = `ADC_RESET_WAIT_CYCLES
) (
	input wire logic synthesized_clock_8_333Mhz,
	input wire logic reset_n,
	input wire logic spi_drdy_n_i,
	input wire init_cmd_t cmd_i,
	input wire logic reply_valid_i,
	input wire logic reply_ok_i,
	input wire logic frame_done_i,
	output init_step_t step_o,
	output frame_req_t frame_req_o,
	output logic spi_reset_n_o,
	output logic adc_ready_o
);

	localparam reset_count_t LOW_LAST = reset_count_t'(RESET_LOW_CYCLES - 1);
	localparam reset_count_t WAIT_LAST = reset_count_t'(RESET_WAIT_CYCLES - 1);

	ctrl_state_e state_q;
	reset_count_t cnt_q;
	init_step_t step_q;
	frame_req_t req_q;
	logic [2:0] drdy_sync_q; // Two sync flops plus edge history
	logic drdy_fall;
	logic in_flight_q;

	assign drdy_fall = drdy_sync_q[2] & ~drdy_sync_q[1];

	// ----------------------------------------------------------------------
	// Sequencing FSM
	// ----------------------------------------------------------------------
	always_ff @(posedge synthesized_clock_8_333Mhz) begin
		if (!reset_n) begin
			state_q <= ST_RESET_LOW;
			cnt_q <= '0;
			step_q <= '0;
			req_q <= '0;
		end else begin
			req_q.start <= 1'b0; // Strobe lasts one cycle
			case (state_q)
				ST_RESET_LOW: begin
					if (cnt_q == LOW_LAST) begin
						cnt_q <= '0;
						state_q <= ST_RESET_WAIT;
					end else begin
						cnt_q <= cnt_q + 1'b1;
					end
				end
				ST_RESET_WAIT: begin
					if (cnt_q == WAIT_LAST) begin
						cnt_q <= '0;
						state_q <= ST_INIT_SEND;
					end else begin
						cnt_q <= cnt_q + 1'b1;
					end
				end
				ST_INIT_SEND: begin
					req_q.start <= 1'b1;
					req_q.tx_word <= cmd_i.cmd;
					req_q.word_count <= frame_len_t'(1); // Init replies fit in one word
					req_q.read <= 1'b0;
					state_q <= ST_INIT_WAIT;
				end
				ST_INIT_WAIT: begin
					if (reply_valid_i) begin
						if (!reply_ok_i) begin
							state_q <= ST_INIT_SEND; // Same step again
						end else if (cmd_i.last) begin
							state_q <= ST_READY;
						end else begin
							step_q <= step_q + 1'b1;
							state_q <= ST_INIT_SEND;
						end
					end
				end
				ST_READY: begin
					if (drdy_fall) begin
						req_q.start <= 1'b1;
						req_q.tx_word <= '0; // Reads clock out zeros
						req_q.word_count <= frame_len_t'(`ADC_READ_WORDS);
						req_q.read <= 1'b1;
						state_q <= ST_READ_WAIT;
					end
				end
				ST_READ_WAIT: begin
					if (frame_done_i)
						state_q <= ST_READY; // Edges seen meanwhile are dropped
				end
				default: state_q <= ST_RESET_LOW;
			endcase
		end
	end

	// Data-ready synchronizer, parked high until init is done
	always_ff @(posedge synthesized_clock_8_333Mhz) begin
		if (!reset_n)
			drdy_sync_q <= '1;
		else if (adc_ready_o)
			drdy_sync_q <= {drdy_sync_q[1:0], spi_drdy_n_i};
		else
			drdy_sync_q <= '1;
	end

	// Tracks a frame between its strobe and frame_done
	always_ff @(posedge synthesized_clock_8_333Mhz) begin
		if (!reset_n)
			in_flight_q <= 1'b0;
		else if (req_q.start)
			in_flight_q <= 1'b1;
		else if (frame_done_i)
			in_flight_q <= 1'b0;
	end

	assign step_o = step_q;
	assign frame_req_o = req_q;
	assign spi_reset_n_o = (state_q != ST_RESET_LOW);
	assign adc_ready_o = (state_q == ST_READY) || (state_q == ST_READ_WAIT);

	// One frame at a time, the engine ignores a start while busy
	assert property (@(posedge synthesized_clock_8_333Mhz) disable iff (!reset_n)
		req_q.start |-> !in_flight_q);

endmodule

`default_nettype wire

// File: hw/spi_frame_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "adc_spi_macros.svh"

module spi_frame_engine
	import adc_spi_pkg::*;
(
	input wire logic synthesized_clock_8_333Mhz,
	input wire logic reset_n,
	input wire frame_req_t req_i,
	input wire logic spi_miso_i,
	output logic spi_sclk_o,
	output logic spi_cs_n_o,
	output logic spi_mosi_o,
	output rx_word_t rx_o,
	output logic frame_done_o
);

	localparam int BIT_W = $clog2(`ADC_WORD_BITS);
	localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(`ADC_WORD_BITS - 1);

	logic busy_q;
	logic sclk_q; // High in the first cycle of each bit
	logic cs_n_q;
	logic mosi_q;
	logic done_q;
	logic [BIT_W-1:0] bit_idx_q;
	frame_len_t word_idx_q;
	frame_len_t last_word_q;
	spi_word_t tx_shift_q;
	spi_word_t rx_shift_q;
	logic rx_valid_q;
	frame_len_t rx_index_q;
	spi_word_t rx_data_q;
	logic bit_end;
	logic frame_end;

	assign bit_end = (bit_idx_q == LAST_BIT);
	assign frame_end = bit_end && (word_idx_q == last_word_q);

	// ----------------------------------------------------------------------
	// Control, one bit per two system clocks
	// ----------------------------------------------------------------------
	always_ff @(posedge synthesized_clock_8_333Mhz) begin
		if (!reset_n) begin
			busy_q <= 1'b0;
			sclk_q <= 1'b0;
			cs_n_q <= 1'b1;
			mosi_q <= 1'b0;
			done_q <= 1'b0;
			rx_valid_q <= 1'b0;
			bit_idx_q <= '0;
			word_idx_q <= '0;
			last_word_q <= '0;
		end else begin
			done_q <= 1'b0;
			rx_valid_q <= 1'b0;
			if (!busy_q) begin
				if (req_i.start) begin
					busy_q <= 1'b1;
					cs_n_q <= 1'b0;
					sclk_q <= 1'b1;
					mosi_q <= req_i.tx_word[`ADC_WORD_BITS-1];
					bit_idx_q <= '0;
					word_idx_q <= '0;
					last_word_q <= req_i.word_count - 1'b1;
				end
			end else if (sclk_q) begin
				sclk_q <= 1'b0; // Falling half, slave holds MISO
			end else begin
				// End of the falling half, MISO is taken here
				bit_idx_q <= bit_idx_q + 1'b1;
				if (bit_end) begin
					rx_valid_q <= 1'b1;
					word_idx_q <= word_idx_q + 1'b1;
				end
				if (frame_end) begin
					busy_q <= 1'b0;
					cs_n_q <= 1'b1;
					mosi_q <= 1'b0;
					done_q <= 1'b1;
				end else begin
					sclk_q <= 1'b1;
					mosi_q <= tx_shift_q[`ADC_WORD_BITS-1]; // Changes with the rising edge
				end
			end
		end
	end

	// Shift registers
	always_ff @(posedge synthesized_clock_8_333Mhz) begin
		if (!busy_q && req_i.start) begin
			tx_shift_q <= {req_i.tx_word[`ADC_WORD_BITS-2:0], 1'b0};
		end else if (busy_q && !sclk_q) begin
			tx_shift_q <= {tx_shift_q[`ADC_WORD_BITS-2:0], 1'b0}; // Zeros after word 0
			rx_shift_q <= {rx_shift_q[`ADC_WORD_BITS-2:0], spi_miso_i};
			if (bit_end) begin
				rx_data_q <= {rx_shift_q[`ADC_WORD_BITS-2:0], spi_miso_i};
				rx_index_q <= word_idx_q;
			end
		end
	end

	assign spi_sclk_o = sclk_q;
	assign spi_cs_n_o = cs_n_q;
	assign spi_mosi_o = mosi_q;
	assign frame_done_o = done_q;
	assign rx_o = '{valid: rx_valid_q, index: rx_index_q, data: rx_data_q};

	// Serial clock only toggles inside a frame
	assert property (@(posedge synthesized_clock_8_333Mhz) disable iff (!reset_n)
		spi_sclk_o |-> !spi_cs_n_o);

endmodule

`default_nettype wire

// File: hw/adc_response_check.sv
`timescale 1ns/1ps
`default_nettype none

`include "adc_spi_macros.svh"

module adc_response_check
	import adc_spi_pkg::*;
(
	input wire logic synthesized_clock_8_333Mhz,
	input wire logic reset_n,
	input wire rx_word_t rx_i,
	input wire logic read_frame_i,
	input wire spi_word_t expected_i,
	input wire logic frame_done_i,
	output logic reply_valid_o,
	output logic reply_ok_o,
	output adc_sample_t sample_o,
	output logic sample_valid_o
);

	localparam int CH_W = $clog2(`ADC_CHANNELS);

	logic ok_q; // Match result of word 0
	logic ok_now;
	logic first_word;
	logic [CH_W-1:0] ch_sel;
	adc_sample_t sample_q;

	assign first_word = rx_i.valid && (rx_i.index == '0);
	assign ok_now = first_word ? (rx_i.data == expected_i) : ok_q;
	assign ch_sel = CH_W'(rx_i.index - frame_len_t'(1)); // Word 1 is channel 0

	// ----------------------------------------------------------------------
	// Init replies
	// ----------------------------------------------------------------------
	always_ff @(posedge synthesized_clock_8_333Mhz) begin
		if (!reset_n) begin
			ok_q <= 1'b0;
			reply_valid_o <= 1'b0;
			reply_ok_o <= 1'b0;
			sample_valid_o <= 1'b0;
		end else begin
			if (first_word && !read_frame_i)
				ok_q <= ok_now;
			reply_valid_o <= frame_done_i && !read_frame_i;
			if (frame_done_i && !read_frame_i)
				reply_ok_o <= ok_now; // Level holds until the next init frame
			sample_valid_o <= frame_done_i && read_frame_i;
		end
	end

	// Read words land in the sample by index
	always_ff @(posedge synthesized_clock_8_333Mhz) begin
		if (rx_i.valid && read_frame_i) begin
			if (rx_i.index == '0)
				sample_q.status <= rx_i.data;
			else
				sample_q.channel[ch_sel] <= rx_i.data;
		end
	end

	assign sample_o = sample_q;

	// Word count set by the controller bounds the engine's index
	assert property (@(posedge synthesized_clock_8_333Mhz) disable iff (!reset_n)
		rx_i.valid |-> rx_i.index < frame_len_t'(`ADC_READ_WORDS));

endmodule

`default_nettype wire

// File: hw/adc_spi_master.sv
`timescale 1ns/1ps
`default_nettype none

`include "adc_spi_macros.svh"

module adc_spi_master
	import adc_spi_pkg::*;
#(
	parameter int RESET_LOW_CYCLES = `ADC_RESET_LOW_CYCLES,
	parameter int RESET_WAIT_CYCLES = `ADC_RESET_WAIT_CYCLES
) (
	input wire logic synthesized_clock_8_333Mhz,
	input wire logic reset_n,
	input wire logic spi_miso_i,
	input wire logic spi_drdy_n_i,
	output logic spi_sclk_o,
	output logic spi_cs_n_o,
	output logic spi_mosi_o,
	output logic spi_reset_n_o,
	output logic adc_ready_o,
	output adc_sample_t sample_o,
	output logic sample_valid_o
);

	init_step_t step;
	init_cmd_t init_cmd;
	frame_req_t frame_req;
	rx_word_t rx_word;
	logic frame_done;
	logic reply_valid;
	logic reply_ok;

	// ----------------------------------------------------------------------
	// Command decoder and sequencer
	// ----------------------------------------------------------------------
	adc_init_decoder u_decode (
		.step_i (step),
		.cmd_o (init_cmd)
	);

	adc_sequence_ctrl #(
		.RESET_LOW_CYCLES (RESET_LOW_CYCLES),
		.RESET_WAIT_CYCLES (RESET_WAIT_CYCLES)
	) u_ctrl (
		.synthesized_clock_8_333Mhz (synthesized_clock_8_333Mhz),
		.reset_n (reset_n),
		.spi_drdy_n_i (spi_drdy_n_i),
		.cmd_i (init_cmd),
		.reply_valid_i (reply_valid),
		.reply_ok_i (reply_ok),
		.frame_done_i (frame_done),
		.step_o (step),
		.frame_req_o (frame_req),
		.spi_reset_n_o (spi_reset_n_o),
		.adc_ready_o (adc_ready_o)
	);

	// Frame engine on the SPI pins
	spi_frame_engine u_execute (
		.synthesized_clock_8_333Mhz (synthesized_clock_8_333Mhz),
		.reset_n (reset_n),
		.req_i (frame_req),
		.spi_miso_i (spi_miso_i),
		.spi_sclk_o (spi_sclk_o),
		.spi_cs_n_o (spi_cs_n_o),
		.spi_mosi_o (spi_mosi_o),
		.rx_o (rx_word),
		.frame_done_o (frame_done)
	);

	adc_response_check u_result (
		.synthesized_clock_8_333Mhz (synthesized_clock_8_333Mhz),
		.reset_n (reset_n),
		.rx_i (rx_word),
		.read_frame_i (frame_req.read), // Held for the whole frame
		.expected_i (init_cmd.expected),
		.frame_done_i (frame_done),
		.reply_valid_o (reply_valid),
		.reply_ok_o (reply_ok),
		.sample_o (sample_o),
		.sample_valid_o (sample_valid_o)
	);

endmodule

`default_nettype wire

// File: tests/adc_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "adc_spi_macros.svh"

module adc_model
	import adc_spi_pkg::*;
(
	input wire logic clk_i,
	input wire logic adc_reset_n_i,
	input wire logic spi_sclk_i,
	input wire logic spi_cs_n_i,
	input wire logic spi_mosi_i,
	input wire logic drdy_req_i,
	input wire logic [3:0] fault_step_i, // Init step whose reply is corrupted once
	input wire adc_sample_t words_i,
	output logic spi_miso_o,
	output logic spi_drdy_n_o
);

	spi_word_t cmd_log [0:15]; // Word 0 of every init frame seen on MOSI
	int cmd_count = 0;
	int step = 0;
	int bit_cnt = 0;
	int word_idx = 0;
	logic mosi_seen = 1'b0; // Any MOSI one during a read frame
	logic fault_used = 1'b0;
	logic faulted = 1'b0;
	logic sclk_d = 1'b0;
	logic cs_d = 1'b1;
	spi_word_t shift = '0; // MOSI bits of the current word
	spi_word_t tx_word = '0; // Word being served on MISO

	initial spi_miso_o = 1'b0;

	assign spi_drdy_n_o = !drdy_req_i;

	function automatic spi_word_t cmd_for(input int s);
		case (s)
			0: cmd_for = 32'h0000_0000;
			1: cmd_for = 32'h0655_0000;
			2: cmd_for = 32'h4B68_0000;
			3: cmd_for = 32'h4C3E_0000;
			4: cmd_for = 32'h4D02_0000;
			5: cmd_for = 32'h4E25_0000;
			6: cmd_for = 32'h4F0F_0000;
			7: cmd_for = 32'h0033_0000;
			default: cmd_for = 32'h0555_0000;
		endcase
	endfunction

	// Reply matches the command sent in the same frame
	function automatic spi_word_t reply_for(input int s);
		case (s)
			0: reply_for = 32'hFF04_0000;
			2: reply_for = 32'h2B68_0000;
			3: reply_for = 32'h2C3E_0000;
			4: reply_for = 32'h2D02_0000;
			5: reply_for = 32'h2E25_0000;
			6: reply_for = 32'h2F0F_0000;
			default: reply_for = cmd_for(s);
		endcase
	endfunction

	function automatic spi_word_t word_out(input int s, input int w, input logic bad);
		if (s >= `ADC_INIT_STEPS) begin
			if (w == 0)
				word_out = words_i.status;
			else if (w <= `ADC_CHANNELS)
				word_out = words_i.channel[w-1];
			else
				word_out = '0;
		end else if (w == 0) begin
			word_out = bad ? ~reply_for(s) : reply_for(s);
		end else begin
			word_out = '0;
		end
	endfunction

	// ----------------------------------------------------------------------
	// Slave side, edges of SCLK and CS seen through the system clock
	// ----------------------------------------------------------------------
	always @(posedge clk_i) begin
		if (!adc_reset_n_i) begin
			step = 0;
			cmd_count = 0;
			bit_cnt = 0;
			word_idx = 0;
			mosi_seen = 1'b0;
			fault_used = 1'b0;
			faulted = 1'b0;
			spi_miso_o <= 1'b0;
		end else begin
			if (!spi_cs_n_i && cs_d) begin
				bit_cnt = 0;
				word_idx = 0;
				faulted = (step == int'(fault_step_i)) && !fault_used;
				if (faulted)
					fault_used = 1'b1;
			end
			if (!spi_cs_n_i && spi_sclk_i && !sclk_d) begin
				tx_word = word_out(step, word_idx, faulted);
				spi_miso_o <= tx_word[31-bit_cnt];
			end
			if (!spi_cs_n_i && !spi_sclk_i && sclk_d) begin
				shift = {shift[30:0], spi_mosi_i};
				if (step >= `ADC_INIT_STEPS && spi_mosi_i)
					mosi_seen = 1'b1;
				bit_cnt++;
				if (bit_cnt == `ADC_WORD_BITS) begin
					bit_cnt = 0;
					if (word_idx == 0 && step < `ADC_INIT_STEPS && cmd_count < 16) begin
						cmd_log[cmd_count] = shift;
						cmd_count++;
					end
					word_idx++;
				end
			end
			// Frame end, advance only on a clean reply to the right command
			if (spi_cs_n_i && !cs_d && step < `ADC_INIT_STEPS && cmd_count > 0) begin
				if (!faulted && cmd_log[cmd_count-1] == cmd_for(step))
					step++;
			end
		end
		sclk_d = spi_sclk_i;
		cs_d = spi_cs_n_i;
	end

endmodule

`default_nettype wire

// File: tests/tb_adc_spi_master.sv
`timescale 1ns/1ps
`default_nettype none

`include "adc_spi_macros.svh"

module tb_adc_spi_master
	import adc_spi_pkg::*;
;

	localparam int LOW_CYC = 20;
	localparam int WAIT_CYC = 40;
	localparam int INIT_FRAME = 70; // 66 cycles plus reply turnaround
	localparam int READ_FRAME = `ADC_READ_WORDS * 2 * `ADC_WORD_BITS + 4;
	localparam int LIMIT = 3 * (LOW_CYC + WAIT_CYC + 10 * INIT_FRAME)
		+ 6 * (READ_FRAME + 500) + 2000;

	logic clk;
	logic reset_n;
	logic spi_miso, spi_drdy_n;
	logic spi_sclk, spi_cs_n, spi_mosi, spi_reset_n;
	logic adc_ready;
	adc_sample_t sample;
	logic sample_valid;
	logic drdy_req;
	logic [3:0] fault_step;
	adc_sample_t words;
	int cycles = 0;
	int sample_count = 0;
	logic [31:0] rng = 32'hc27d60bb;

	adc_spi_master #(
		.RESET_LOW_CYCLES (LOW_CYC),
		.RESET_WAIT_CYCLES (WAIT_CYC)
	) UUT (
		.synthesized_clock_8_333Mhz (clk),
		.reset_n (reset_n),
		.spi_miso_i (spi_miso),
		.spi_drdy_n_i (spi_drdy_n),
		.spi_sclk_o (spi_sclk),
		.spi_cs_n_o (spi_cs_n),
		.spi_mosi_o (spi_mosi),
		.spi_reset_n_o (spi_reset_n),
		.adc_ready_o (adc_ready),
		.sample_o (sample),
		.sample_valid_o (sample_valid)
	);

	adc_model adc (
		.clk_i (clk),
		.adc_reset_n_i (spi_reset_n),
		.spi_sclk_i (spi_sclk),
		.spi_cs_n_i (spi_cs_n),
		.spi_mosi_i (spi_mosi),
		.drdy_req_i (drdy_req),
		.fault_step_i (fault_step),
		.words_i (words),
		.spi_miso_o (spi_miso),
		.spi_drdy_n_o (spi_drdy_n)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ----------------------------------------------------------------------
	// Timeout and sample counting
	// ----------------------------------------------------------------------
	always @(posedge clk) begin
		cycles++;
		if (cycles > LIMIT) begin
			$display("Simulation ran out of cycles before the tests finished");
			$display("test failed");
			$fatal(1);
		end
	end

	always @(negedge clk) begin
		if (sample_valid === 1'b1)
			sample_count++;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic spi_word_t init_word(input int s);
		case (s)
			0: init_word = 32'h0000_0000;
			1: init_word = 32'h0655_0000;
			2: init_word = 32'h4B68_0000;
			3: init_word = 32'h4C3E_0000;
			4: init_word = 32'h4D02_0000;
			5: init_word = 32'h4E25_0000;
			6: init_word = 32'h4F0F_0000;
			7: init_word = 32'h0033_0000;
			default: init_word = 32'h0555_0000;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [159:0] got,
			input logic [159:0] exp);
		if (got !== exp) begin
			$display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
			$display("test failed");
			$fatal(1);
		end
	endtask

	task automatic apply_reset();
		reset_n = 1'b0;
		repeat (2) @(posedge clk);
		#1 reset_n = 1'b1;
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		while (adc_ready !== 1'b1) begin
			@(negedge clk);
			n++;
			if (n > 12 * INIT_FRAME + LOW_CYC + WAIT_CYC) begin
				$display("ADC ready never came up after the init sequence");
				$display("test failed");
				$fatal(1);
			end
		end
	endtask

	task automatic reset_timing_test();
		int low, gap;
		apply_reset();
		@(negedge clk);
		check_value("spi_cs_n_o", spi_cs_n, 1);
		check_value("adc_ready_o", adc_ready, 0);
		check_value("sample_valid_o", sample_valid, 0);
		low = 1;
		while (spi_reset_n === 1'b0 && low < 1000) begin
			@(negedge clk);
			if (spi_reset_n === 1'b0)
				low++;
		end
		check_value("spi_reset_n_o low cycles", low, LOW_CYC);
		gap = 0;
		while (spi_cs_n === 1'b1 && gap < 1000) begin
			@(negedge clk);
			gap++;
		end
		check_value("frame start after ADC reset", gap >= WAIT_CYC, 1);
	endtask

	task automatic init_sequence_test();
		wait_ready();
		check_value("init frame count", adc.cmd_count, `ADC_INIT_STEPS);
		for (int i = 0; i < `ADC_INIT_STEPS; i++)
			check_value("init command", adc.cmd_log[i], init_word(i));
	endtask

	task automatic init_retry_test();
		@(posedge clk);
		#1 fault_step = 4'd3; // Reply to 4C3E
		apply_reset();
		wait_ready();
		check_value("init frame count", adc.cmd_count, `ADC_INIT_STEPS + 1);
		for (int i = 0; i <= 3; i++)
			check_value("init command", adc.cmd_log[i], init_word(i));
		check_value("repeated command", adc.cmd_log[4], init_word(3));
		for (int i = 5; i <= `ADC_INIT_STEPS; i++)
			check_value("init command", adc.cmd_log[i], init_word(i - 1));
		fault_step = 4'hF;
	endtask

	task automatic pulse_drdy();
		@(posedge clk);
		#1 drdy_req = 1'b1;
		repeat (4) @(posedge clk);
		#1 drdy_req = 1'b0;
	endtask

	task automatic wait_sample();
		int n;
		n = 0;
		@(negedge clk);
		while (sample_valid !== 1'b1) begin
			@(negedge clk);
			n++;
			if (n > READ_FRAME + 50) begin
				$display("No sample strobe after a data-ready edge");
				$display("test failed");
				$fatal(1);
			end
		end
	endtask

	task automatic read_sample_test(input int count, input logic extra_edge);
		int start_count;
		start_count = sample_count;
		for (int k = 0; k < count; k++) begin
			rng = xorshift(rng);
			words.status = rng;
			for (int c = 0; c < `ADC_CHANNELS; c++) begin
				rng = xorshift(rng);
				words.channel[c] = rng;
			end
			pulse_drdy();
			if (extra_edge) begin
				repeat (100) @(posedge clk); // Lands inside the read frame
				pulse_drdy();
			end
			wait_sample();
			check_value("sample_o", sample, words);
			repeat (READ_FRAME + 100) @(posedge clk);
		end
		check_value("sample count", sample_count - start_count, count);
		check_value("MOSI during reads", adc.mosi_seen, 0);
	endtask

	// ----------------------------------------------------------------------
	// Test sequence
	// ----------------------------------------------------------------------
	initial begin
		reset_n = 1'b0;
		drdy_req = 1'b0;
		fault_step = 4'hF;
		words = '0;
		reset_timing_test();
		init_sequence_test();
		init_retry_test();
		read_sample_test(1, 1'b1);
		read_sample_test(2, 1'b0);
		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
+incdir+hw
hw/adc_spi_pkg.sv
hw/adc_init_decoder.sv
hw/adc_sequence_ctrl.sv
hw/spi_frame_engine.sv
hw/adc_response_check.sv
hw/adc_spi_master.sv
tests/adc_model.sv
tests/tb_adc_spi_master.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f \
	--top-module tb_adc_spi_master -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "test failed" sim.log; then
	exit 1
fi
exit 0
